/* icache.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_lookup_if.sv
logic/icache_fill_if.sv
logic/icache_addr_decode.sv
logic/icache_ctrl.sv
logic/icache_store.sv
logic/icache_response.sv
logic/icache_top.sv
test/icache_assert.sv
test/icache_tb.sv

/* Makefile */
# Verilator flow for the instruction cache testbench

TOOL     := verilator
FLAGS    := --timing --assert --timescale 1ns/100ps
TOP      := icache_tb
FILELIST := icache.f

BUILD    := obj_dir
PASS_MSG := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the run prints the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

/* test/icache_tb.sv */
`default_nettype none

`include "icache_consts.svh"

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_REQ = 400;
  localparam int NUM_DIRECTED = 6;
  localparam int CYCLES_PER_REQ = 100;
  localparam int WATCHDOG_NS = (NUM_REQ + NUM_DIRECTED) * CYCLES_PER_REQ * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'h1b2a_9da7;
  // memory word at byte address a is a ^ MEM_XOR
  localparam logic [31:0] MEM_XOR = 32'h5ee3_1c07;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic req_valid_i = 1'b0;
  icache_pkg::word_t req_addr_i = '0;
  logic mem_rvalid_i = 1'b0;
  icache_pkg::word_t mem_rdata_i = '0;
  logic rsp_valid_o;
  icache_pkg::word_t rsp_data_o;
  logic mem_valid_o;
  icache_pkg::word_t mem_addr_o;
  logic mem_burst_o;

  // request stream and memory gaps draw from separate seed variables
  integer stim_seed = SEED;
  integer mem_seed = SEED;

  // memory model state
  logic mem_active = 1'b0;
  icache_pkg::word_t mem_base = '0;
  logic [31:0] mem_beat = '0;
  logic [31:0] mem_len = '0;
  logic [31:0] mem_starts = '0;
  logic [31:0] beat_total = '0;
  // what the next memory request should look like
  icache_pkg::word_t exp_mem_addr = '0;
  logic exp_mem_burst = 1'b0;

  // mirror of valid bits and tags
  logic model_valid [`ICACHE_LINES];
  icache_pkg::tag_t model_tag [`ICACHE_LINES];

  icache_top DUT (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .mem_valid_o  (mem_valid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_burst_o  (mem_burst_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input icache_pkg::word_t got, input icache_pkg::word_t exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // four tags only so lines get reused and evicted
  function automatic icache_pkg::tag_t pick_tag(input logic [1:0] sel);
    case (sel)
      2'd0: return 19'h0_0000;
      2'd1: return 19'h0_0001;
      2'd2: return 19'h1_2345;
      default: return 19'h6_5a5a;
    endcase
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      req_valid_i <= 1'b0;
    end
  endtask

  // one request held until the response and checked against the mirror
  task automatic run_request(input icache_pkg::word_t addr);
    icache_pkg::index_t idx;
    icache_pkg::tag_t tag;
    logic uncached;
    logic exp_hit;
    logic [31:0] starts_before;
    logic [31:0] beats_before;
    int cycles;
    idx = addr[12:6];
    tag = addr[31:13];
    uncached = (addr[31:28] == `ICACHE_UNCACHED_NIBBLE);
    exp_hit = !uncached && model_valid[idx] && (model_tag[idx] == tag);
    cycles = 0;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_addr_i <= addr;
    exp_mem_addr = uncached ? addr : {addr[31:6], 6'b0};
    exp_mem_burst = !uncached;
    starts_before = mem_starts;
    beats_before = beat_total;
    do begin
      @(negedge clk);
      cycles++;
    end while (!rsp_valid_o);
    check_value(rsp_data_o, addr ^ MEM_XOR, "response word");
    if (uncached) begin
      check_value(mem_starts - starts_before, 32'd1, "uncached memory requests");
      check_value(beat_total - beats_before, 32'd1, "uncached beats");
    end else if (exp_hit) begin
      // idle cycle then the lookup cycle carrying the response
      check_value(32'(cycles), 32'd2, "hit latency in cycles");
      check_value(mem_starts - starts_before, 32'd0, "memory requests on a hit");
    end else begin
      check_value(mem_starts - starts_before, 32'd1, "refill requests on a miss");
      check_value(beat_total - beats_before, 32'(`ICACHE_WORDS_PER_LINE), "refill beats");
      model_valid[idx] = 1'b1;
      model_tag[idx] = tag;
    end
  endtask

  // memory side bookkeeping sampled away from the active edge
  always @(negedge clk) begin
    if (rst) begin
      mem_active = 1'b0;
    end else if (mem_valid_o && !mem_active) begin
      check_value(mem_addr_o, exp_mem_addr, "memory address");
      check_value(32'(mem_burst_o), 32'(exp_mem_burst), "memory burst flag");
      mem_active = 1'b1;
      mem_base = mem_addr_o;
      mem_beat = '0;
      mem_len = mem_burst_o ? 32'(`ICACHE_WORDS_PER_LINE) : 32'd1;
      mem_starts = mem_starts + 1;
    end else if (mem_valid_o && mem_rvalid_i) begin
      mem_beat = mem_beat + 1;
      beat_total = beat_total + 1;
      // no more data after the last beat
      if (mem_beat == mem_len) begin
        mem_active = 1'b0;
      end
    end
  end

  // about 70 percent of open cycles carry a beat
  always @(posedge clk) begin
    mem_rvalid_i <= mem_active && (({$random(mem_seed)} % 100) < 70);
    mem_rdata_i <= (mem_base + (mem_beat << 2)) ^ MEM_XOR;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the cache stopped answering before all requests were done");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    icache_pkg::word_t addr;
    logic [31:0] roll;
    int i;
    for (i = 0; i < `ICACHE_LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
    end
    // outputs stay quiet over the five reset edges
    repeat (4) begin
      @(negedge clk);
      check_value(32'(rsp_valid_o), 32'd0, "rsp_valid_o during reset");
      check_value(32'(mem_valid_o), 32'd0, "mem_valid_o during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value(32'(rsp_valid_o), 32'd0, "rsp_valid_o after reset");
    check_value(32'(mem_valid_o), 32'd0, "mem_valid_o after reset");
    // directed cold miss, hit, conflict eviction and two uncached reads
    run_request(32'h0000_1040);
    run_request(32'h0000_1044);
    run_request(32'h0000_3040);
    run_request(32'h0000_1048);
    run_request(32'hA000_0100);
    run_request(32'hA000_0100);
    for (i = 0; i < NUM_REQ; i++) begin
      roll = $random(stim_seed);
      // one in eight goes to a few uncached words
      if (roll[2:0] == 3'd0) begin
        addr = {`ICACHE_UNCACHED_NIBBLE, 23'd0, roll[5:3], 2'b00};
      end else begin
        addr = {pick_tag(roll[4:3]), 2'b00, roll[9:5], roll[13:10], 2'b00};
      end
      if (roll[15:14] == 2'b00) begin
        idle_cycles(int'(roll[17:16]) + 1);
      end
      run_request(addr);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/icache_assert.sv */
`default_nettype none

module icache_assert (
  input wire logic clk,
  input wire logic rst,
  input wire logic rsp_valid_i,
  input wire logic mem_valid_i,
  input wire icache_pkg::word_t mem_addr_i,
  input wire logic mem_burst_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // reset as seen at the last two edges
  logic rst_q1 = 1'b0;
  logic rst_q2 = 1'b0;

  always @(posedge clk) begin
    rst_q1 <= rst;
    rst_q2 <= rst_q1;
  end

  // response and memory request never overlap
  assert property (@(posedge clk) disable iff (rst) !(rsp_valid_i && mem_valid_i))
    else $error("response raised while a memory request is open");

  // request fields held for the whole transfer
  assert property (@(posedge clk) disable iff (rst)
                   mem_valid_i |=> $stable(mem_addr_i) && $stable(mem_burst_i))
    else $error("memory address or burst flag changed during a request");

  // quiet memory port through reset and just after
  assert property (@(posedge clk) (rst_q1 || rst_q2) |-> !mem_valid_i)
    else $error("memory request raised in or right after reset");

endmodule

bind icache_top icache_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .rsp_valid_i (rsp_valid_o),
  .mem_valid_i (mem_valid_o),
  .mem_addr_i  (mem_addr_o),
  .mem_burst_i (mem_burst_o)
);

`default_nettype wire

/* logic/icache_top.sv */
`default_nettype none

module icache_top (
  input wire logic clk,
  input wire logic rst,
  // fetch port
  input wire logic req_valid_i,
  input wire icache_pkg::word_t req_addr_i,
  output logic rsp_valid_o,
  output icache_pkg::word_t rsp_data_o,
  // memory port
  output logic mem_valid_o,
  output icache_pkg::word_t mem_addr_o,
  output logic mem_burst_o,
  input wire logic mem_rvalid_i,
  input wire icache_pkg::word_t mem_rdata_i
);

  icache_lookup_if lookup_if ();
  icache_fill_if fill_if ();

  logic hit;
  logic hit_done;
  logic unc_beat;
  icache_pkg::word_t rd_word;

  // request address register and field split
  icache_addr_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .req_addr_i (req_addr_i),
    .lookup     (lookup_if.decode)
  );

  // lookup, refill and uncached read sequencing
  icache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (req_valid_i),
    .hit_i        (hit),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_valid_o  (mem_valid_o),
    .mem_addr_o   (mem_addr_o),
    .mem_burst_o  (mem_burst_o),
    .hit_done_o   (hit_done),
    .unc_beat_o   (unc_beat),
    .lookup       (lookup_if.ctrl),
    .fill         (fill_if.ctrl)
  );

  // tag, valid and data arrays
  icache_store u_store (
    .clk       (clk),
    .rst       (rst),
    .hit_o     (hit),
    .rd_word_o (rd_word),
    .lookup    (lookup_if.store),
    .fill      (fill_if.store)
  );

  // response word select and timing
  icache_response u_response (
    .clk         (clk),
    .rst         (rst),
    .hit_done_i  (hit_done),
    .unc_beat_i  (unc_beat),
    .rd_word_i   (rd_word),
    .mem_rdata_i (mem_rdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o)
  );

endmodule

`default_nettype wire

/* logic/icache_response.sv */
`default_nettype none

module icache_response (
  input wire logic clk,
  input wire logic rst,
  input wire logic hit_done_i,
  input wire logic unc_beat_i,
  input wire icache_pkg::word_t rd_word_i,
  input wire icache_pkg::word_t mem_rdata_i,
  output logic rsp_valid_o,
  output icache_pkg::word_t rsp_data_o
);

  // word of the last uncached beat
  icache_pkg::word_t unc_data_q;
  // uncached word ready, one cycle only
  logic unc_ready_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      unc_ready_q <= 1'b0;
    end else begin
      unc_ready_q <= unc_beat_i;
    end
  end

  always_ff @(posedge clk) begin
    if (unc_beat_i) begin
      unc_data_q <= mem_rdata_i;
    end
  end

  // hit responds in the lookup cycle, uncached one edge after its beat
  assign rsp_valid_o = hit_done_i | unc_ready_q;

  // array word unless an uncached word is pending
  assign rsp_data_o = unc_ready_q ? unc_data_q : rd_word_i;

endmodule

`default_nettype wire

/* logic/icache_store.sv */
`default_nettype none

`include "icache_consts.svh"

module icache_store (
  input wire logic clk,
  input wire logic rst,
  output logic hit_o,
  output icache_pkg::word_t rd_word_o,
  icache_lookup_if.store lookup,
  icache_fill_if.store fill
);

  localparam int DATA_WORDS = `ICACHE_LINES * `ICACHE_WORDS_PER_LINE;
  localparam int DATA_AW = `ICACHE_INDEX_W + `ICACHE_WORD_SEL_W;

  icache_pkg::tag_t tag_mem [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] valid_q;
  icache_pkg::word_t data_mem [DATA_WORDS];

  logic [DATA_AW-1:0] rd_addr;
  logic [DATA_AW-1:0] wr_addr;

  // word address is line index then word in line
  assign rd_addr = {lookup.index, lookup.word_sel};
  assign wr_addr = {fill.fill_index, fill.fill_word};

  // hit when the line is valid and tags agree
  assign hit_o = valid_q[lookup.index] && (tag_mem[lookup.index] == lookup.tag);
  assign rd_word_o = data_mem[rd_addr];

  // valid bits, all lines empty after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill.tag_we) begin
      valid_q[fill.fill_index] <= 1'b1;
    end
  end

  // tag of the line just filled
  always_ff @(posedge clk) begin
    if (fill.tag_we) begin
      tag_mem[fill.fill_index] <= lookup.tag;
    end
  end

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (fill.data_we) begin
      data_mem[wr_addr] <= fill.fill_data;
    end
  end

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl (
  input wire logic clk,
  input wire logic rst,
  input wire logic req_valid_i,
  input wire logic hit_i,
  input wire logic mem_rvalid_i,
  input wire icache_pkg::word_t mem_rdata_i,
  output logic mem_valid_o,
  output icache_pkg::word_t mem_addr_o,
  output logic mem_burst_o,
  output logic hit_done_o,
  output logic unc_beat_o,
  icache_lookup_if.ctrl lookup,
  icache_fill_if.ctrl fill
);

  icache_pkg::icache_state_e state_q;
  icache_pkg::word_sel_t beat_cnt;
  logic tag_we_q;
  logic beat;
  logic last_beat;
  logic decide;

  // a beat is any cycle with both levels high
  assign beat = mem_valid_o & mem_rvalid_i;
  assign last_beat = (beat_cnt == icache_pkg::word_sel_t'(`ICACHE_WORDS_PER_LINE - 1));

  // lookup result is stale while the tag write is pending
  assign decide = (state_q == icache_pkg::ST_LOOKUP) && !tag_we_q;

  // new address is only taken in idle
  assign lookup.capture = (state_q == icache_pkg::ST_IDLE);

  assign hit_done_o = decide && !lookup.uncached && hit_i;
  assign unc_beat_o = (state_q == icache_pkg::ST_UNCACHED) && beat;

  // refill beats go straight into the data array
  assign fill.data_we = (state_q == icache_pkg::ST_REFILL) && beat;
  assign fill.fill_index = lookup.index;
  assign fill.fill_word = beat_cnt;
  assign fill.fill_data = mem_rdata_i;
  assign fill.tag_we = tag_we_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::ST_IDLE;
      mem_valid_o <= 1'b0;
      beat_cnt <= '0;
      tag_we_q <= 1'b0;
    end else begin
      // single cycle pulse
      tag_we_q <= 1'b0;
      case (state_q)
        icache_pkg::ST_IDLE: begin
          if (req_valid_i) begin
            state_q <= icache_pkg::ST_LOOKUP;
          end
        end
        icache_pkg::ST_LOOKUP: begin
          if (decide) begin
            // uncached wins, those lines are never allocated
            if (lookup.uncached) begin
              state_q <= icache_pkg::ST_UNCACHED;
              mem_valid_o <= 1'b1;
            end else if (hit_i) begin
              state_q <= icache_pkg::ST_IDLE;
            end else begin
              state_q <= icache_pkg::ST_REFILL;
              mem_valid_o <= 1'b1;
              beat_cnt <= '0;
            end
          end
        end
        icache_pkg::ST_REFILL: begin
          if (beat) begin
            beat_cnt <= beat_cnt + 4'd1;
            // whole line in, write the tag then look up again
            if (last_beat) begin
              mem_valid_o <= 1'b0;
              tag_we_q <= 1'b1;
              state_q <= icache_pkg::ST_LOOKUP;
            end
          end
        end
        icache_pkg::ST_UNCACHED: begin
          // extra cycle covers the response so the held address is not retaken
          if (beat) begin
            mem_valid_o <= 1'b0;
          end else if (!mem_valid_o) begin
            state_q <= icache_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= icache_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // memory request fields, loaded on every lookup decision
  always_ff @(posedge clk) begin
    if (decide) begin
      if (lookup.uncached) begin
        mem_addr_o <= {lookup.tag, lookup.index, lookup.word_sel, 2'b00};
      end else begin
        mem_addr_o <= {lookup.tag, lookup.index, {(`ICACHE_WORD_SEL_W + 2){1'b0}}};
      end
      mem_burst_o <= !lookup.uncached;
    end
  end

endmodule

`default_nettype wire

/* logic/icache_addr_decode.sv */
`default_nettype none

`include "icache_consts.svh"

module icache_addr_decode (
  input wire logic clk,
  input wire logic rst,
  input wire icache_pkg::word_t req_addr_i,
  icache_lookup_if.decode lookup
);

  // bit positions of the fields
  localparam int WORD_LSB = 2;
  localparam int INDEX_LSB = WORD_LSB + `ICACHE_WORD_SEL_W;

  icache_pkg::tag_t tag_d;
  icache_pkg::index_t index_d;
  icache_pkg::word_sel_t word_sel_d;
  logic uncached_d;

  // split the raw address and drop the byte offset
  assign tag_d = req_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign index_d = req_addr_i[INDEX_LSB +: `ICACHE_INDEX_W];
  assign word_sel_d = req_addr_i[WORD_LSB +: `ICACHE_WORD_SEL_W];

  // uncached region picked by the top nibble
  assign uncached_d = (req_addr_i[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNCACHED_NIBBLE);

  // uncached flag for the controller
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup.uncached <= 1'b0;
    end else if (lookup.capture) begin
      lookup.uncached <= uncached_d;
    end
  end

  // address fields held until the next capture
  always_ff @(posedge clk) begin
    if (lookup.capture) begin
      lookup.tag <= tag_d;
      lookup.index <= index_d;
      lookup.word_sel <= word_sel_d;
    end
  end

endmodule

`default_nettype wire

/* logic/icache_fill_if.sv */
`default_nettype none

// array write commands from the controller
interface icache_fill_if;

  // one data word per refill beat
  logic data_we;
  icache_pkg::index_t fill_index;
  icache_pkg::word_sel_t fill_word;
  icache_pkg::word_t fill_data;
  // line complete, write tag and set valid
  logic tag_we;

  modport ctrl (
    output data_we,
    output fill_index,
    output fill_word,
    output fill_data,
    output tag_we
  );

  modport store (
    input data_we,
    input fill_index,
    input fill_word,
    input fill_data,
    input tag_we
  );

endinterface

`default_nettype wire

/* logic/icache_lookup_if.sv */
`default_nettype none

// registered request fields, shared by the lookup stages
interface icache_lookup_if;

  icache_pkg::tag_t tag;
  icache_pkg::index_t index;
  icache_pkg::word_sel_t word_sel;
  // request targets the uncached region
  logic uncached;
  // controller asks for a new address to be registered
  logic capture;

  modport decode (
    output tag,
    output index,
    output word_sel,
    output uncached,
    input capture
  );

  modport ctrl (
    input tag,
    input index,
    input word_sel,
    input uncached,
    output capture
  );

  modport resp (
    input tag,
    input index,
    input word_sel,
    input uncached,
    input capture
  );

  // arrays only need the address fields
  modport store (
    input tag,
    input index,
    input word_sel
  );

endinterface

`default_nettype wire

/* logic/icache_pkg.sv */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // controller states, reset lands in idle
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } icache_state_e;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t;

  // instruction or memory word
  typedef logic [`ICACHE_ADDR_W-1:0] word_t;

endpackage

`default_nettype wire

/* logic/icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address and data word width
`define ICACHE_ADDR_W 32

// address split: tag | index | word select | byte offset
`define ICACHE_TAG_W 19
`define ICACHE_INDEX_W 7
`define ICACHE_WORD_SEL_W 4

// 8 KB direct mapped, 64 byte lines
`define ICACHE_LINES 128
`define ICACHE_WORDS_PER_LINE 16

// top address nibble of the uncached region
`define ICACHE_UNCACHED_NIBBLE 4'hA

`endif
